/* hw/bd_readout_pkg.sv */
package bd_readout_pkg;

  // longest leaf payload once the funnel deserializer is done with it
  localparam int n_payload = 38;
  // payload bits per host word
  localparam int n_out = 24;
  // funnel leaves, codes 13 to 15 are unused
  localparam int n_leaf = 13;

  // funnel leaf codes in horn endpoint order
  typedef enum logic [3:0] {
    dump_am   = 4'd0,
    dump_pat  = 4'd1,
    dump_reg  = 4'd2,
    dump_pre  = 4'd3,
    dump_post = 4'd4,
    dump_ctrl = 4'd5,
    dump_tat0 = 4'd6,
    dump_tat1 = 4'd7,
    spike     = 4'd8,
    ovflw0    = 4'd9,
    ovflw1    = 4'd10,
    ro_acc    = 4'd11,
    ro_tat    = 4'd12
  } leaf_e;

  // true payload width per leaf, indexed by leaf code
  localparam int leaf_width [0:n_leaf-1] = '{
    38, 11, 17, 20, 24, 19, 29, 29, 16, 24, 12, 28, 32
  };

  // word as it leaves the funnel, leaf code not yet checked
  typedef struct packed {
    logic [3:0]           leaf;
    logic [n_payload-1:0] payload;
  } raw_word_t;

  // checked leaf, payload cut to the leaf width
  typedef struct packed {
    leaf_e                leaf;
    logic [n_payload-1:0] payload;
  } dec_word_t;

  // host word, part 0 carries the low payload bits
  typedef struct packed {
    leaf_e              leaf;
    logic               part;
    logic [n_out-1:0]   payload;
  } pc_word_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } ctrl_state_e;

endpackage

/* hw/bd_funnel_decoder.sv */
`timescale 1ns/1ps

module bd_funnel_decoder (
  input  logic                      clk,
  input  logic                      reset,
  input  bd_readout_pkg::raw_word_t in_word,
  input  logic                      in_fire,
  output logic                      dec_ready,
  output bd_readout_pkg::dec_word_t dec_word,
  output logic                      dec_valid,
  input  logic                      dec_ack,
  output logic                      drop
);

  import bd_readout_pkg::*;

  logic                 legal;
  logic [n_payload-1:0] width_mask;
  dec_word_t            next_word;

  // payload mask for one leaf, all ones up to the leaf width
  function automatic logic [n_payload-1:0] leaf_mask(input logic [3:0] code);
    logic [n_payload-1:0] mask;
    mask = '0;
    // walk the table so an unused code never indexes past its end
    for (int l = 0; l < n_leaf; l++) begin
      if (code == l[3:0]) begin
        mask = {n_payload{1'b1}} >> (n_payload - leaf_width[l]);
      end
    end
    return mask;
  endfunction

  // codes 13 and up have no leaf behind them
  assign legal = (in_word.leaf < 4'(n_leaf));

  assign width_mask = leaf_mask(in_word.leaf);

  always_comb begin
    next_word.leaf    = leaf_e'(in_word.leaf);
    // stray bits above the leaf width are cleared here once
    next_word.payload = in_word.payload & width_mask;
  end

  // one slot, free when empty or when its word leaves this cycle
  assign dec_ready = !dec_valid || dec_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid <= 1'b0;
      drop      <= 1'b0;
    end else begin
      // illegal word is swallowed, only the pulse shows it was seen
      drop <= in_fire && !legal;
      if (in_fire && legal) begin
        dec_valid <= 1'b1;
      end else if (dec_ack) begin
        dec_valid <= 1'b0;
      end
    end
  end

  // payload slot
  always_ff @(posedge clk) begin
    if (in_fire && legal) begin
      dec_word <= next_word;
    end
  end

endmodule

/* hw/bd_word_serializer.sv */
`timescale 1ns/1ps

module bd_word_serializer (
  input  logic                      clk,
  input  logic                      reset,
  input  bd_readout_pkg::dec_word_t dec_word,
  input  logic                      dec_valid,
  output logic                      dec_ack,
  output bd_readout_pkg::pc_word_t  ser_word,
  output logic                      ser_valid,
  input  logic                      ser_ack,
  output logic                      mid_word
);

  import bd_readout_pkg::*;

  // payload bits left over for the high part
  localparam int n_hi = n_payload - n_out;

  typedef enum logic {
    s_low,
    s_high
  } ser_state_e;

  ser_state_e state;
  ser_state_e next_state;
  logic       split;
  logic       last_part;
  logic       fire;

  // leaf wider than a host word needs a second part
  function automatic logic needs_split(input leaf_e leaf);
    logic result;
    result = 1'b0;
    for (int l = 0; l < n_leaf; l++) begin
      if (leaf == leaf_e'(l)) begin
        result = (leaf_width[l] > n_out);
      end
    end
    return result;
  endfunction

  assign split = needs_split(dec_word.leaf);

  assign fire = ser_valid && ser_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= s_low;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      s_low: begin
        // low part went out, high part is still owed
        if (fire && split) begin
          next_state = s_high;
        end
      end
      s_high: begin
        if (fire) begin
          next_state = s_low;
        end
      end
      default: next_state = s_low;
    endcase
  end

  // input word stays put until every part of it is gone
  assign ser_valid = dec_valid;

  always_comb begin
    ser_word.leaf = dec_word.leaf;
    ser_word.part = (state == s_high);
    if (state == s_high) begin
      // top bits already zero above the leaf width from the decoder
      ser_word.payload = {{(n_out - n_hi){1'b0}}, dec_word.payload[n_payload-1:n_out]};
    end else begin
      ser_word.payload = dec_word.payload[n_out-1:0];
    end
  end

  // release the decoder slot on the final part only
  assign last_part = (state == s_high) || !split;
  assign dec_ack   = fire && last_part;

  assign mid_word = (state == s_high);

endmodule

/* hw/bd_output_queue.sv */
`timescale 1ns/1ps

module bd_output_queue #(
  parameter int fifo_depth = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  bd_readout_pkg::pc_word_t ser_word,
  input  logic                     ser_valid,
  output logic                     ser_ack,
  output bd_readout_pkg::pc_word_t out_word,
  output logic                     out_valid,
  input  logic                     out_ack,
  output logic                     empty
);

  import bd_readout_pkg::*;

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  pc_word_t         mem [0:fifo_depth-1];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  // pointer step with wrap for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count == cnt_w'(fifo_depth));
  assign empty = (count == '0);

  // a full queue still takes a word when the host drains one now
  assign ser_ack = !full || out_ack;

  assign out_valid = !empty;
  assign out_word  = mem[rd_ptr];

  assign push = ser_valid && ser_ack;
  assign pop  = out_valid && out_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // occupancy holds when both happen together
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= ser_word;
    end
  end

endmodule

/* hw/bd_readout_ctrl.sv */
`timescale 1ns/1ps

module bd_readout_ctrl (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        dec_ready,
  input  logic        in_valid,
  output logic        in_ack,
  input  logic        drop,
  input  logic        mid_word,
  input  logic        dec_valid,
  input  logic        queue_empty,
  input  logic        out_fire,
  output logic        busy,
  output logic [15:0] drop_count,
  output logic [15:0] word_count
);

  import bd_readout_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        pipe_empty;

  // nothing held in decoder, serializer or queue
  assign pipe_empty = !dec_valid && !mid_word && queue_empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (enable) begin
          next_state = st_run;
        end
      end
      st_run: begin
        // stop intake, let what is inside finish
        if (!enable) begin
          next_state = st_drain;
        end
      end
      st_drain: begin
        if (pipe_empty) begin
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  // ack only against a pending word, so it is also the decoder capture strobe
  assign in_ack = in_valid && dec_ready && (state == st_run);

  assign busy = (state != st_idle);

  // status counters, free running, wrap at 16 bits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drop_count <= '0;
      word_count <= '0;
    end else begin
      if (drop) begin
        drop_count <= drop_count + 16'd1;
      end
      if (out_fire) begin
        word_count <= word_count + 16'd1;
      end
    end
  end

endmodule

/* hw/bd_readout_top.sv */
`timescale 1ns/1ps

module bd_readout_top #(
  parameter int fifo_depth = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable,
  input  bd_readout_pkg::raw_word_t in_word,
  input  logic                      in_valid,
  output logic                      in_ack,
  output bd_readout_pkg::pc_word_t  out_word,
  output logic                      out_valid,
  input  logic                      out_ack,
  output logic                      busy,
  output logic [15:0]               drop_count,
  output logic [15:0]               word_count
);

  import bd_readout_pkg::*;

  // decoder to serializer
  dec_word_t dec_word;
  logic      dec_valid;
  logic      dec_ack;
  logic      dec_ready;
  logic      drop;

  // serializer to queue
  pc_word_t  ser_word;
  logic      ser_valid;
  logic      ser_ack;
  logic      mid_word;

  logic      queue_empty;

  // host side transfer, counted as a sent word
  wire       out_fire = out_valid && out_ack;

  bd_readout_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .dec_ready   (dec_ready),
    .in_valid    (in_valid),
    .in_ack      (in_ack),
    .drop        (drop),
    .mid_word    (mid_word),
    .dec_valid   (dec_valid),
    .queue_empty (queue_empty),
    .out_fire    (out_fire),
    .busy        (busy),
    .drop_count  (drop_count),
    .word_count  (word_count)
  );

  // in_ack already includes in_valid, so it marks each accepted word
  bd_funnel_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .in_word   (in_word),
    .in_fire   (in_ack),
    .dec_ready (dec_ready),
    .dec_word  (dec_word),
    .dec_valid (dec_valid),
    .dec_ack   (dec_ack),
    .drop      (drop)
  );

  bd_word_serializer u_serializer (
    .clk       (clk),
    .reset     (reset),
    .dec_word  (dec_word),
    .dec_valid (dec_valid),
    .dec_ack   (dec_ack),
    .ser_word  (ser_word),
    .ser_valid (ser_valid),
    .ser_ack   (ser_ack),
    .mid_word  (mid_word)
  );

  bd_output_queue #(
    .fifo_depth (fifo_depth)
  ) u_queue (
    .clk       (clk),
    .reset     (reset),
    .ser_word  (ser_word),
    .ser_valid (ser_valid),
    .ser_ack   (ser_ack),
    .out_word  (out_word),
    .out_valid (out_valid),
    .out_ack   (out_ack),
    .empty     (queue_empty)
  );

endmodule

/* verif/tb_bd_readout_model.svh */
// payload width of each funnel leaf, indexed by leaf code
localparam int ref_width [0:12] = '{38, 11, 17, 20, 24, 19, 29, 29, 16, 24, 12, 28, 32};

// fibonacci lfsr, taps 16 14 13 11, one step per bit taken
function automatic logic [37:0] lfsr_bits(inout logic [15:0] state, input int n);
  logic [37:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
    state = {state[14:0], fb};
    r     = {r[36:0], fb};
  end
  return r;
endfunction

// host words owed for one raw word, low part first
function automatic void expand_word(input raw_word_t w);
  int                   width;
  logic [n_payload-1:0] kept;
  pc_word_t             hw;
  // codes 13 to 15 have no leaf and give no output
  if (w.leaf > 4'd12) begin
    return;
  end
  width = ref_width[w.leaf];
  kept  = '0;
  for (int b = 0; b < n_payload; b++) begin
    if (b < width) begin
      kept[b] = w.payload[b];
    end
  end
  hw.leaf    = leaf_e'(w.leaf);
  hw.part    = 1'b0;
  hw.payload = kept[n_out-1:0];
  exp_q.push_back(hw);
  exp_words++;
  // wider than one host word, high bits follow zero-extended
  if (width > n_out) begin
    hw.part    = 1'b1;
    hw.payload = {{(2 * n_out - n_payload){1'b0}}, kept[n_payload-1:n_out]};
    exp_q.push_back(hw);
    exp_words++;
  end
endfunction

task automatic check_word(input pc_word_t exp, input pc_word_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error out_word: expected %h actual %h", exp, act);
  end
endtask

task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected %h actual %h", name, exp, act);
  end
endtask

/* verif/tb_bd_readout_top.sv */
`timescale 1ns/1ps

module tb_bd_readout_top;

  import bd_readout_pkg::*;

  localparam int period = 100;
  localparam int seed = 62062;
  localparam int n_split_rep = 2;
  localparam int n_mixed = 12;
  localparam int n_random = 400;
  localparam int n_before_stop = 20;
  localparam int n_resume = 10;
  // all words offered including the one held while draining
  localparam int n_issued = n_leaf + 5 * n_split_rep + 2 * n_mixed + n_random
                            + n_before_stop + 1 + n_resume;
  localparam int watchdog_cycles = n_issued * 4 + 200;

  logic        clk;
  logic        reset;
  logic        enable;
  raw_word_t   in_word;
  logic        in_valid;
  logic        in_ack;
  pc_word_t    out_word;
  logic        out_valid;
  logic        out_ack;
  logic        busy;
  logic [15:0] drop_count;
  logic [15:0] word_count;

  // host words still owed by the DUT in arrival order
  pc_word_t    exp_q [$];
  pc_word_t    owed;
  int          exp_words = 0;
  int          exp_drops = 0;
  int          errors = 0;
  int          checks = 0;
  int          test_errors = 0;
  logic        random_ack = 1'b0;
  logic [15:0] word_lfsr;
  logic [15:0] ack_lfsr;
  logic [37:0] ack_bits;

  `include "tb_bd_readout_model.svh"

  bd_readout_top #(
    .fifo_depth (8)
  ) bd_readout_top_i (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .in_word    (in_word),
    .in_valid   (in_valid),
    .in_ack     (in_ack),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ack    (out_ack),
    .busy       (busy),
    .drop_count (drop_count),
    .word_count (word_count)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * period);
    $display("timeout: output stream stalled, run stopped after %0d cycles", watchdog_cycles);
    $display("Regression failed");
    $finish;
  end

  // host accepts every cycle or on a coin flip
  always @(negedge clk) begin
    if (random_ack) begin
      ack_bits = lfsr_bits(ack_lfsr, 1);
      out_ack  = ack_bits[0];
    end else begin
      out_ack = 1'b1;
    end
  end

  // every host transfer takes the oldest owed word
  always @(posedge clk) begin
    if (!reset && out_valid && out_ack) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected output word %h arrived with nothing owed", out_word);
      end else begin
        owed = exp_q.pop_front();
        check_word(owed, out_word);
      end
    end
  end

  function automatic raw_word_t random_word();
    raw_word_t   w;
    logic [37:0] bits;
    bits      = lfsr_bits(word_lfsr, 4);
    w.leaf    = bits[3:0];
    bits      = lfsr_bits(word_lfsr, n_payload);
    w.payload = bits;
    return w;
  endfunction

  // wait for the handshake on the word on offer, then note what it owes
  task automatic await_accept(input raw_word_t w);
    @(posedge clk);
    while (!in_ack) @(posedge clk);
    if (w.leaf > 4'd12) begin
      exp_drops++;
    end
    expand_word(w);
  endtask

  // hold the word until the DUT takes it
  task automatic send_word(input raw_word_t w);
    @(negedge clk);
    in_word  = w;
    in_valid = 1'b1;
    await_accept(w);
  endtask

  task automatic close_test(input string name);
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    // drop counter trails its word by two edges
    repeat (3) @(negedge clk);
    check_count("drop_count", exp_drops[15:0], drop_count);
    check_count("word_count", exp_words[15:0], word_count);
    $display("%s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    raw_word_t w;
    reset     = 1'b1;
    enable    = 1'b0;
    in_word   = '0;
    in_valid  = 1'b0;
    out_ack   = 1'b0;
    word_lfsr = 16'(seed);
    ack_lfsr  = 16'(seed);
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset  = 1'b0;
    enable = 1'b1;

    // all payload bits set so the width cut shows
    for (int l = 0; l < n_leaf; l++) begin
      w.leaf    = 4'(l);
      w.payload = '1;
      send_word(w);
    end
    close_test("test 1 every leaf");

    for (int r = 0; r < n_split_rep; r++) begin
      w = random_word();
      foreach (ref_width[l]) begin
        if (ref_width[l] > n_out) begin
          w.leaf = 4'(l);
          send_word(w);
        end
      end
    end
    close_test("test 2 two-part leaves");

    // illegal codes interleaved with legal ones
    for (int i = 0; i < n_mixed; i++) begin
      w = random_word();
      w.leaf = 4'(i % n_leaf);
      send_word(w);
      w = random_word();
      w.leaf = 4'(13 + i % 3);
      send_word(w);
    end
    close_test("test 3 illegal leaves");

    random_ack = 1'b1;
    for (int i = 0; i < n_random; i++) begin
      send_word(random_word());
    end
    close_test("test 4 random traffic");

    for (int i = 0; i < n_before_stop; i++) begin
      send_word(random_word());
    end
    // stop intake with words still inside
    @(negedge clk);
    in_valid = 1'b0;
    enable   = 1'b0;
    @(negedge clk);
    w        = random_word();
    in_word  = w;
    in_valid = 1'b1;
    do begin
      @(posedge clk);
      if (in_ack) begin
        errors++;
        $display("in_ack went high while enable was low");
      end
    end while (busy);
    if (exp_q.size() != 0) begin
      errors++;
      $display("busy fell with %0d host words still owed", exp_q.size());
    end
    // the word held during the drain goes in first once intake resumes
    @(negedge clk);
    enable = 1'b1;
    await_accept(w);
    for (int i = 0; i < n_resume; i++) begin
      send_word(random_word());
    end
    close_test("test 5 drain and resume");

    $display("checks %0d, errors %0d, host words %0d, drops %0d",
             checks, errors, exp_words, exp_drops);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* bd_readout_top.f */
+incdir+verif
hw/bd_readout_pkg.sv
hw/bd_funnel_decoder.sv
hw/bd_word_serializer.sv
hw/bd_output_queue.sv
hw/bd_readout_ctrl.sv
hw/bd_readout_top.sv
verif/tb_bd_readout_top.sv

/* Makefile */
BIN = obj_dir/Vtb_bd_readout_top

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

$(BIN): bd_readout_top.f $(wildcard hw/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing -j 0 --top-module tb_bd_readout_top -f bd_readout_top.f

clean:
	rm -rf obj_dir

.PHONY: run clean
